/* Bender.yml */
package:
  name: key_periph

sources:
  - files:
      - common/key_pkg.sv
      - common/bus_pkg.sv
      - common/key_event_if.sv
      - key_debounce/key_debounce.sv
      - hdl/event_fifo.sv
      - hdl/key_regs.sv
      - hdl/key_periph_top.sv
  - target: test
    files:
      - tb/key_periph_assertions.sv
      - tb/tb_key_periph.sv

/* common/bus_pkg.sv */
`default_nettype none

package bus_pkg;

    localparam int bus_addr_w = 4;
    localparam int bus_data_w = 32;

    // register offsets
    localparam logic [bus_addr_w-1:0] reg_status = 4'h0;
    localparam logic [bus_addr_w-1:0] reg_event  = 4'h4;
    localparam logic [bus_addr_w-1:0] reg_ctrl   = 4'h8;

    // status fields
    localparam int status_evt_bit  = 0;  // event waiting
    localparam int status_keys_lsb = 4;  // committed key levels

    // event fields, a read pops the fifo head
    localparam int event_pressed_lsb  = 0;
    localparam int event_released_lsb = 4;
    localparam int event_valid_bit    = 8;

    // ctrl fields
    localparam int ctrl_irq_en_bit = 0;

endpackage

`default_nettype wire

/* common/key_event_if.sv */
`default_nettype none

// valid/ready stream of key events
interface key_event_if;
    import key_pkg::*;

    logic                valid;
    logic                ready;
    logic [num_keys-1:0] pressed;
    logic [num_keys-1:0] released;

    // producer holds valid and payload until ready
    modport source (
        output valid,
        output pressed,
        output released,
        input  ready
    );

    modport sink (
        input  valid,
        input  pressed,
        input  released,
        output ready
    );

endinterface

`default_nettype wire

/* common/key_pkg.sv */
`default_nettype none

package key_pkg;

    // keys are active low, a released key reads 1
    localparam int num_keys = 4;

    localparam logic [num_keys-1:0] key_idle = '1;

    // stable cycles before a new level is taken, 1 ms at 25 MHz
    localparam int filter_default = 25000;

    // events buffered between filter and register block
    localparam int fifo_depth = 4;

    // one byte per event
    typedef struct packed {
        logic [num_keys-1:0] pressed;   // went high to low
        logic [num_keys-1:0] released;  // went low to high
    } key_event_t;

endpackage

`default_nettype wire

/* hdl/event_fifo.sv */
`default_nettype none

module event_fifo (
    input  wire                  clk,
    input  wire                  rst_n,
    key_event_if.sink            in_ev,
    output logic                 out_valid,
    input  wire                  out_ready,
    output key_pkg::key_event_t  out_event
);
    import key_pkg::*;

    localparam int ptr_w = $clog2(fifo_depth);
    localparam int cnt_w = $clog2(fifo_depth + 1);

    key_event_t       mem [fifo_depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             wr_en;
    logic             rd_en;

    assign in_ev.ready = (count != cnt_w'(fifo_depth));  // low when full
    assign out_valid   = (count != '0);
    assign out_event   = mem[rd_ptr];

    assign wr_en = in_ev.valid & in_ev.ready;
    assign rd_en = out_valid & out_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == ptr_w'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == ptr_w'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // idle or push and pop together
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= '{pressed: in_ev.pressed, released: in_ev.released};
        end
    end

endmodule

`default_nettype wire

/* hdl/key_periph_top.sv */
`default_nettype none

module key_periph_top #(
    parameter int filter_cycles = key_pkg::filter_default
) (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire  [key_pkg::num_keys-1:0]   keys,
    input  wire                            bus_sel,
    input  wire                            bus_we,
    input  wire  [bus_pkg::bus_addr_w-1:0] bus_addr,
    input  wire  [bus_pkg::bus_data_w-1:0] bus_wdata,
    output logic [bus_pkg::bus_data_w-1:0] bus_rdata,
    output logic                           bus_ack,
    output logic                           irq
);
    import key_pkg::*;

    logic                fifo_valid;
    logic                fifo_ready;
    key_event_t          fifo_event;
    logic [num_keys-1:0] stable_keys;

    key_event_if ev_if ();

    // filter to fifo over the event stream
    key_debounce #(
        .filter_cycles (filter_cycles)
    ) u_debounce (
        .clk         (clk),
        .rst_n       (rst_n),
        .keys        (keys),
        .ev          (ev_if.source),
        .stable_keys (stable_keys)
    );

    event_fifo u_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_ev     (ev_if.sink),
        .out_valid (fifo_valid),
        .out_ready (fifo_ready),
        .out_event (fifo_event)
    );

    key_regs u_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .bus_sel     (bus_sel),
        .bus_we      (bus_we),
        .bus_addr    (bus_addr),
        .bus_wdata   (bus_wdata),
        .bus_rdata   (bus_rdata),
        .bus_ack     (bus_ack),
        .ev_valid    (fifo_valid),
        .ev_ready    (fifo_ready),
        .ev_data     (fifo_event),
        .stable_keys (stable_keys),
        .irq         (irq)
    );

endmodule

`default_nettype wire

/* hdl/key_regs.sv */
`default_nettype none

module key_regs (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire                            bus_sel,
    input  wire                            bus_we,
    input  wire  [bus_pkg::bus_addr_w-1:0] bus_addr,
    input  wire  [bus_pkg::bus_data_w-1:0] bus_wdata,
    output logic [bus_pkg::bus_data_w-1:0] bus_rdata,
    output logic                           bus_ack,
    input  wire                            ev_valid,
    output logic                           ev_ready,
    input  wire  key_pkg::key_event_t      ev_data,
    input  wire  [key_pkg::num_keys-1:0]   stable_keys,
    output logic                           irq
);
    import key_pkg::*;
    import bus_pkg::*;

    logic                  req;         // access sampled on this edge
    logic                  irq_en;
    logic                  irq_en_nxt;
    logic                  pop_q;       // pop the head in the ack cycle
    logic [bus_data_w-1:0] rd_mux;

    assign req = bus_sel & ~bus_ack;

    // only pop what was actually returned
    assign ev_ready = bus_ack & pop_q;

    always_comb begin
        irq_en_nxt = irq_en;
        if (req && bus_we && (bus_addr == reg_ctrl)) begin
            irq_en_nxt = bus_wdata[ctrl_irq_en_bit];
        end
    end

    always_comb begin
        rd_mux = '0;
        case (bus_addr)
            reg_status: begin
                rd_mux[status_evt_bit]             = ev_valid;
                rd_mux[status_keys_lsb +: num_keys] = stable_keys;
            end
            reg_event: begin
                if (ev_valid) begin  // empty fifo reads as 0
                    rd_mux[event_pressed_lsb +: num_keys]  = ev_data.pressed;
                    rd_mux[event_released_lsb +: num_keys] = ev_data.released;
                    rd_mux[event_valid_bit]                = 1'b1;
                end
            end
            reg_ctrl: begin
                rd_mux[ctrl_irq_en_bit] = irq_en;
            end
            default: begin
                rd_mux = '0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bus_ack <= 1'b0;
            irq_en  <= 1'b0;
            irq     <= 1'b0;
            pop_q   <= 1'b0;
        end else begin
            bus_ack <= req;  // one cycle after sel rises
            irq_en  <= irq_en_nxt;
            // follows the new enable so irq never outlives it
            irq     <= irq_en_nxt & ev_valid;
            pop_q   <= req & ~bus_we & (bus_addr == reg_event) & ev_valid;
        end
    end

    // read data held for the ack cycle
    always_ff @(posedge clk) begin
        if (req) begin
            bus_rdata <= bus_we ? '0 : rd_mux;
        end
    end

endmodule

`default_nettype wire

/* key_debounce/key_debounce.sv */
`default_nettype none

module key_debounce #(
    parameter int filter_cycles = key_pkg::filter_default
) (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire  [key_pkg::num_keys-1:0] keys,
    key_event_if.source                  ev,
    output logic [key_pkg::num_keys-1:0] stable_keys
);
    import key_pkg::*;

    localparam int cnt_w = $clog2(filter_cycles + 1);

    typedef enum logic {
        st_idle,
        st_filter
    } state_t;

    state_t              state;
    logic [num_keys-1:0] sync_q1;
    logic [num_keys-1:0] sync_q2;
    logic [num_keys-1:0] candidate;  // level under test
    logic [cnt_w-1:0]    count;      // stable cycles still needed
    logic                start;
    logic                commit;

    // no new filtering while an event waits for the fifo
    assign start = (state == st_idle) && !ev.valid && (sync_q2 != stable_keys);

    assign commit = (state == st_filter) && (sync_q2 == candidate) && (count == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q1     <= key_idle;
            sync_q2     <= key_idle;
            state       <= st_idle;
            count       <= '0;
            stable_keys <= key_idle;
            ev.valid    <= 1'b0;
        end else begin
            sync_q1 <= keys;
            sync_q2 <= sync_q1;

            if (ev.valid && ev.ready) begin
                ev.valid <= 1'b0;  // taken by the fifo
            end

            case (state)
                st_idle: begin
                    if (start) begin
                        state <= st_filter;
                        count <= cnt_w'(filter_cycles - 1);
                    end
                end
                st_filter: begin
                    if (sync_q2 != candidate) begin
                        // bounce, fall back to committed level
                        state <= st_idle;
                    end else if (commit) begin
                        state       <= st_idle;
                        stable_keys <= candidate;
                        ev.valid    <= 1'b1;
                    end else begin
                        count <= count - 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // candidate and event payload
    always_ff @(posedge clk) begin
        if (start) begin
            candidate <= sync_q2;
        end
        if (commit) begin
            ev.pressed  <= stable_keys & ~candidate;  // 1 -> 0
            ev.released <= candidate & ~stable_keys;  // 0 -> 1
        end
    end

endmodule

`default_nettype wire

/* tb/key_golden.txt */
# op    keys/addr  settle/cycles/wdata  expected (irq for key and hold, data for read), all hex
# key bounces from the LFSR before settling, write ignores the last column
hold  0 2  0
read  0 0  f0
read  4 0  0
key   7 0  0
key   f 1e 0
read  0 0  f0
write 8 1  0
key   b 14 1
read  0 0  b1
read  4 0  104
hold  0 3  0
read  0 0  b0
key   e 14 1
read  4 0  141
write 8 0  0
key   f 14 0
key   7 14 0
key   3 14 0
key   1 14 0
key   0 14 0
key   8 14 0
read  0 0  1
read  4 0  110
read  4 0  108
read  4 0  104
read  4 0  102
read  4 0  101
hold  0 14 0
read  0 0  81
read  4 0  180
read  4 0  0

/* tb/key_periph_assertions.sv */
`default_nettype none

// generic checks, bound into the fifo and the register block
module key_periph_assertions (
    input wire                  clk,
    input wire                  rst_n,
    input wire                  valid,
    input wire                  ready,
    input wire key_pkg::key_event_t payload,
    input wire                  ack,
    input wire                  irq,
    input wire                  irq_en
);

    int fail_count = 0;  // assertion failures so far

    // an event waiting for ready keeps valid and payload
    hold_payload: assert property (
        @(posedge clk) disable iff (!rst_n)
        (valid && !ready) |=> (valid && $stable(payload))
    ) else begin
        fail_count++;
        $error("event payload or valid changed while ready was low");
    end

    single_ack: assert property (
        @(posedge clk) disable iff (!rst_n)
        ack |=> !ack
    ) else begin
        fail_count++;
        $error("bus_ack high for two cycles in a row");
    end

    irq_gated: assert property (
        @(posedge clk) disable iff (!rst_n)
        irq |-> irq_en
    ) else begin
        fail_count++;
        $error("irq high while irq_en is clear");
    end

endmodule

bind event_fifo key_periph_assertions u_fifo_sva (
    .clk     (clk),
    .rst_n   (rst_n),
    .valid   (in_ev.valid),
    .ready   (in_ev.ready),
    .payload ({in_ev.pressed, in_ev.released}),
    .ack     (1'b0),     // no bus on this side
    .irq     (1'b0),
    .irq_en  (1'b0)
);

bind key_regs key_periph_assertions u_regs_sva (
    .clk     (clk),
    .rst_n   (rst_n),
    .valid   (ev_valid),
    .ready   (ev_ready),
    .payload (ev_data),
    .ack     (bus_ack),
    .irq     (irq),
    .irq_en  (irq_en)
);

`default_nettype wire

/* tb/tb_key_periph.sv */
`default_nettype none

module tb_key_periph;
    import key_pkg::*;
    import bus_pkg::*;

    localparam int          filter_len   = 8;
    localparam int          reset_cycles = 4;
    localparam logic [31:0] lfsr_taps    = 32'h8020_0003;  // x^32 + x^22 + x^2 + x + 1

    logic                  clk;
    logic                  rst_n;
    logic [num_keys-1:0]   keys;
    logic                  bus_sel;
    logic                  bus_we;
    logic [bus_addr_w-1:0] bus_addr;
    logic [bus_data_w-1:0] bus_wdata;
    logic [bus_data_w-1:0] bus_rdata;
    logic                  bus_ack;
    logic                  irq;

    logic [31:0] lfsr;
    int          err_data;
    int          err_event;
    int          err_irq;
    int          err_other;
    int          err_assert;
    int          cycle_cnt;
    int          cycle_limit;

    // golden steps as opcode and three hex fields
    int          step_op[$];
    logic [31:0] step_a[$];
    logic [31:0] step_b[$];
    logic [31:0] step_c[$];

    key_periph_top #(
        .filter_cycles (filter_len)
    ) UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .keys      (keys),
        .bus_sel   (bus_sel),
        .bus_we    (bus_we),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .bus_rdata (bus_rdata),
        .bus_ack   (bus_ack),
        .irq       (irq)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            $display("timeout, the run exceeded %0d cycles without finishing", cycle_limit);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        lfsr_step = s[0] ? ((s >> 1) ^ lfsr_taps) : (s >> 1);
    endfunction

    function automatic int op_code(input logic [63:0] op);
        case (op)
            "key":   op_code = 0;
            "hold":  op_code = 1;
            "read":  op_code = 2;
            "write": op_code = 3;
            default: op_code = -1;
        endcase
    endfunction

    task automatic take_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | lfsr[0];  // one step per bit
            lfsr = lfsr_step(lfsr);
        end
    endtask

    task automatic check_data(input string name, input logic [bus_data_w-1:0] exp,
                              input logic [bus_data_w-1:0] act);
        if (act !== exp) begin
            err_data++;
            $display("ERR %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_event(input string name, input key_event_t exp, input key_event_t act);
        if (act !== exp) begin
            err_event++;
            $display("ERR %s expected pressed %b released %b actual pressed %b released %b",
                     name, exp.pressed, exp.released, act.pressed, act.released);
        end
    endtask

    task automatic check_irq(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            err_irq++;
            $display("ERR %s expected irq %b actual irq %b", name, exp, act);
        end
    endtask

    // host holds sel until ack, data sampled in the ack cycle
    task automatic bus_access(input logic we, input logic [bus_addr_w-1:0] addr,
                              input logic [bus_data_w-1:0] wdata,
                              output logic [bus_data_w-1:0] rdata);
        @(posedge clk);
        bus_sel   <= 1'b1;
        bus_we    <= we;
        bus_addr  <= addr;
        bus_wdata <= wdata;
        do @(posedge clk); while (!bus_ack);
        rdata = bus_rdata;
        bus_sel <= 1'b0;
    endtask

    // short glitches to the new level, then settle on it
    task automatic drive_keys(input logic [num_keys-1:0] val, input int settle);
        logic [num_keys-1:0] old;
        int                  pulses;
        int                  len;
        old = keys;
        take_bits(2, pulses);
        repeat (pulses) begin
            take_bits(2, len);
            @(posedge clk);
            keys <= val;
            repeat (len + 1) @(posedge clk);  // at most 4 cycles, below filter_len
            keys <= old;
            take_bits(2, len);
            repeat (len) @(posedge clk);
        end
        @(posedge clk);
        keys <= val;
        repeat (settle) @(posedge clk);
    endtask

    initial begin
        int                    fd;
        int                    code;
        string                 line;
        string                 name;
        logic [63:0]           op_r;
        logic [31:0]           a;
        logic [31:0]           b;
        logic [31:0]           c;
        logic [bus_data_w-1:0] rdata;
        key_event_t            exp_ev;
        key_event_t            act_ev;
        int                    limit;
        clk       = 1'b0;
        rst_n     = 1'b0;
        keys      = key_idle;
        bus_sel   = 1'b0;
        bus_we    = 1'b0;
        bus_addr  = '0;
        bus_wdata = '0;
        lfsr      = 32'hfcaa;
        err_data  = 0;
        err_event = 0;
        err_irq   = 0;
        err_other = 0;
        err_assert  = 0;
        cycle_cnt   = 0;
        cycle_limit = 0;
        limit       = reset_cycles + 10;

        fd = $fopen("tb/key_golden.txt", "r");
        if (fd == 0) begin
            err_other++;
            $display("could not open the golden file tb/key_golden.txt");
        end
        while (fd != 0 && !$feof(fd)) begin
            code = $fgets(line, fd);
            if (code > 0 && line.len() > 1 && line.getc(0) != 8'h23) begin  // skip # lines
                code = $sscanf(line, "%s %h %h %h", op_r, a, b, c);
                if (code == 4) begin
                    step_op.push_back(op_code(op_r));
                    step_a.push_back(a);
                    step_b.push_back(b);
                    step_c.push_back(c);
                    if (op_code(op_r) <= 1) begin
                        limit += b;  // hold and settle cycles
                    end
                    if (op_code(op_r) != 1) begin
                        limit += 50;
                    end
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        if (step_op.size() == 0) begin
            err_other++;
            $display("no steps were loaded from the golden file");
        end
        cycle_limit = limit;

        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;

        for (int i = 0; i < step_op.size(); i++) begin
            name = $sformatf("step %0d", i);
            a    = step_a[i];
            b    = step_b[i];
            c    = step_c[i];
            case (step_op[i])
                0: begin
                    drive_keys(a[num_keys-1:0], b);
                    check_irq(name, c[0], irq);
                end
                1: begin
                    repeat (b) @(posedge clk);
                    check_irq(name, c[0], irq);
                end
                2: begin
                    bus_access(1'b0, a[bus_addr_w-1:0], '0, rdata);
                    check_data(name, c, rdata);
                    if (a[bus_addr_w-1:0] == reg_event) begin
                        exp_ev.pressed  = c[3:0];
                        exp_ev.released = c[7:4];
                        act_ev.pressed  = rdata[3:0];
                        act_ev.released = rdata[7:4];
                        check_event(name, exp_ev, act_ev);
                    end
                end
                3: bus_access(1'b1, a[bus_addr_w-1:0], b, rdata);
                default: begin
                    err_other++;
                    $display("%s has an unknown opcode in the golden file", name);
                end
            endcase
        end

        repeat (2) @(posedge clk);
        err_assert = UUT.u_fifo.u_fifo_sva.fail_count + UUT.u_regs.u_regs_sva.fail_count;
        $display("errors: data %0d, event %0d, irq %0d, other %0d, assertion %0d",
                 err_data, err_event, err_irq, err_other, err_assert);
        if (err_data + err_event + err_irq + err_other + err_assert == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
common/key_pkg.sv
common/bus_pkg.sv
common/key_event_if.sv
key_debounce/key_debounce.sv
hdl/event_fifo.sv
hdl/key_regs.sv
hdl/key_periph_top.sv
tb/key_periph_assertions.sv
tb/tb_key_periph.sv
